//--- oramPkg.sv
/*
 * Tree geometry, block field types and the slot word layout of the ORAM backend.
 * Modules refer to these through scoped names.
 */
`default_nettype none

package oramPkg;

	// ----------------------------------------
	// Tree geometry
	// ----------------------------------------
	localparam int TreeLevels = 4;
	localparam int NumLeaves = 8;
	localparam int SlotsPerBucket = 2;
	localparam int NumSlots = 30;
	localparam int StashSize = 8;

	typedef logic [7:0] pAddrT;
	typedef logic [2:0] leafT;
	typedef logic [1:0] levelT;
	typedef logic [31:0] blockDataT;
	typedef logic [4:0] slotAddrT;
	typedef logic [63:0] dramWordT;

	// ----------------------------------------
	// Slot word layout
	// ----------------------------------------
	localparam int WordValidBit = 63;
	localparam int WordPAddrLsb = 55;
	localparam int WordLeafLsb = 52;

	typedef enum logic {cmdRead, cmdWrite} backendCmdT;

	// Valid word, unused bits zero
	function automatic dramWordT packWord(pAddrT addr, leafT leaf, blockDataT data);
		dramWordT word;
		word = '0;
		word[WordValidBit] = 1'b1;
		word[WordPAddrLsb +: $bits(pAddrT)] = addr;
		word[WordLeafLsb +: $bits(leafT)] = leaf;
		word[$bits(blockDataT)-1:0] = data;
		return word;
	endfunction

endpackage

`default_nettype wire

//--- dramPkg.sv
/*
 * DRAM side definitions: command encoding, scramble key and read tag depth.
 */
`default_nettype none

package dramPkg;

	typedef enum logic {dramRead, dramWrite} dramCmdT;

	localparam logic [63:0] ScrambleKey = 64'h3c5a_9e17_d2b4_6f81;

	// Reads the scrambler can have outstanding
	localparam int TagDepth = 4;

	// Key XOR the slot address byte in every byte lane
	function automatic oramPkg::dramWordT slotPad(oramPkg::slotAddrT addr);
		return ScrambleKey ^ {8{8'(addr)}};
	endfunction

endpackage

`default_nettype wire

//--- oramIfs.sv
/*
 * Internal buses of the backend: controller to stash, and controller to scrambler.
 */
`default_nettype none

interface stashIf;
	logic insValid;
	oramPkg::dramWordT insWord;

	logic lookValid;
	oramPkg::pAddrT lookPAddr;
	oramPkg::leafT lookNewLeaf;
	logic lookWrite;
	oramPkg::blockDataT lookData;
	oramPkg::blockDataT lookResult;

	logic evValid;
	oramPkg::leafT evLeaf;
	oramPkg::levelT evLevel;
	logic evFound;
	oramPkg::dramWordT evWord;

	logic overflow;

	modport master(output insValid, insWord, lookValid, lookPAddr, lookNewLeaf, lookWrite,
		lookData, evValid, evLeaf, evLevel, input lookResult, evFound, evWord);
	modport slave(input insValid, insWord, lookValid, lookPAddr, lookNewLeaf, lookWrite,
		lookData, evValid, evLeaf, evLevel, output lookResult, evFound, evWord, overflow);
endinterface

interface dramPortIf;
	oramPkg::slotAddrT addr;
	dramPkg::dramCmdT cmd;
	logic cmdValid;
	logic cmdReady;
	oramPkg::dramWordT rdData;
	logic rdValid;
	logic rdReady;
	oramPkg::dramWordT wrData;
	logic wrValid;
	logic wrReady;

	modport master(output addr, cmd, cmdValid, rdReady, wrData, wrValid,
		input cmdReady, rdData, rdValid, wrReady);
	modport slave(input addr, cmd, cmdValid, rdReady, wrData, wrValid,
		output cmdReady, rdData, rdValid, wrReady);
endinterface

`default_nettype wire

//--- pathAddrGen.sv
/*
 * Walks the slot addresses on one leaf's path, root to leaf or leaf to root.
 * A forward start loads the leaf; a reverse walk retraces the same path.
 */
`default_nettype none

module pathAddrGen (
	input wire logic Clock,
	input wire logic arstN,
	input wire oramPkg::leafT leaf,
	input wire logic start,
	input wire logic advance,
	input wire logic reverse,
	output oramPkg::slotAddrT addr,
	output oramPkg::levelT level,
	output logic last
);
	localparam int SlotW = $clog2(oramPkg::SlotsPerBucket);

	oramPkg::leafT leafQ;
	oramPkg::levelT levelQ;
	logic [SlotW-1:0] slotQ;
	logic backQ;
	logic [3:0] marked;
	logic [3:0] heapIdx;
	logic slotLast;

	// Leaf with a marker bit on top; shifting it gives heap index plus one
	assign marked = 4'(oramPkg::NumLeaves) | {1'b0, leafQ};
	assign heapIdx = (marked >> (2'(oramPkg::TreeLevels - 1) - levelQ)) - 4'd1;
	assign addr = oramPkg::slotAddrT'(heapIdx * oramPkg::SlotsPerBucket)
		+ oramPkg::slotAddrT'(slotQ);
	assign level = levelQ;
	assign slotLast = slotQ == SlotW'(oramPkg::SlotsPerBucket - 1);
	assign last = slotLast && (backQ ? levelQ == '0
		: levelQ == 2'(oramPkg::TreeLevels - 1));

	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN) begin
			levelQ <= '0;
			slotQ <= '0;
			backQ <= 1'b0;
		end else if (start) begin
			levelQ <= reverse ? 2'(oramPkg::TreeLevels - 1) : '0;
			slotQ <= '0;
			backQ <= reverse;
		end else if (advance) begin
			if (slotLast) begin
				slotQ <= '0;
				levelQ <= backQ ? levelQ - 2'd1 : levelQ + 2'd1;
			end else begin
				slotQ <= slotQ + 1'b1;
			end
		end
	end

	always_ff @(posedge Clock) begin
		if (start && !reverse)
			leafQ <= leaf;
	end

endmodule

`default_nettype wire

//--- stash.sv
/*
 * Stash of real blocks held between path read and path write-back.
 * Serves insert, lookup/update and a per-level eviction search.
 */
`default_nettype none

module stash (
	input wire logic Clock,
	input wire logic arstN,
	stashIf.slave port
);
	localparam int IdxW = $clog2(oramPkg::StashSize);

	logic [oramPkg::StashSize-1:0] entValid;
	oramPkg::pAddrT entPAddr [oramPkg::StashSize];
	oramPkg::leafT entLeaf [oramPkg::StashSize];
	oramPkg::blockDataT entData [oramPkg::StashSize];

	logic freeFound, lookHit, evHit;
	logic [IdxW-1:0] freeIdx, lookIdx, evIdx;
	logic [1:0] evShift;

	logic allocReq;
	oramPkg::pAddrT allocPAddr;
	oramPkg::leafT allocLeaf;
	oramPkg::blockDataT allocData;

	// ----------------------------------------
	// Searches, lowest index wins
	// ----------------------------------------
	assign evShift = 2'(oramPkg::TreeLevels - 1) - port.evLevel;

	always_comb begin
		freeFound = 1'b0;
		freeIdx = '0;
		lookHit = 1'b0;
		lookIdx = '0;
		evHit = 1'b0;
		evIdx = '0;
		for (int i = oramPkg::StashSize - 1; i >= 0; i--) begin
			if (!entValid[i]) begin
				freeFound = 1'b1;
				freeIdx = IdxW'(i);
			end
			if (entValid[i] && entPAddr[i] == port.lookPAddr) begin
				lookHit = 1'b1;
				lookIdx = IdxW'(i);
			end
			// Block may live at this level if leaves agree above it
			if (entValid[i] && (entLeaf[i] >> evShift) == (port.evLeaf >> evShift)) begin
				evHit = 1'b1;
				evIdx = IdxW'(i);
			end
		end
	end

	// Path words and newly written blocks share one allocation path
	assign allocReq = port.insValid || (port.lookValid && port.lookWrite && !lookHit);
	assign allocPAddr = port.insValid
		? port.insWord[oramPkg::WordPAddrLsb +: $bits(oramPkg::pAddrT)] : port.lookPAddr;
	assign allocLeaf = port.insValid
		? port.insWord[oramPkg::WordLeafLsb +: $bits(oramPkg::leafT)] : port.lookNewLeaf;
	assign allocData = port.insValid
		? port.insWord[$bits(oramPkg::blockDataT)-1:0] : port.lookData;

	// ----------------------------------------
	// Entry state
	// ----------------------------------------
	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN) begin
			entValid <= '0;
			port.overflow <= 1'b0;
			port.evFound <= 1'b0;
		end else begin
			if (allocReq) begin
				if (freeFound)
					entValid[freeIdx] <= 1'b1;
				else
					port.overflow <= 1'b1;
			end
			if (port.evValid) begin
				port.evFound <= evHit;
				if (evHit)
					entValid[evIdx] <= 1'b0;
			end
		end
	end

	always_ff @(posedge Clock) begin
		if (allocReq && freeFound) begin
			entPAddr[freeIdx] <= allocPAddr;
			entLeaf[freeIdx] <= allocLeaf;
			entData[freeIdx] <= allocData;
		end
		if (port.lookValid) begin
			port.lookResult <= lookHit ? entData[lookIdx] : '0;
			if (lookHit) begin
				entLeaf[lookIdx] <= port.lookNewLeaf;
				if (port.lookWrite)
					entData[lookIdx] <= port.lookData;
			end
		end
		if (port.evValid)
			port.evWord <= evHit
				? oramPkg::packWord(entPAddr[evIdx], entLeaf[evIdx], entData[evIdx]) : '0;
	end

endmodule

`default_nettype wire

//--- pathScrambler.sv
/*
 * Pad scrambler between the backend and DRAM, standing in for AES.
 * One register stage each way; read pads come from a FIFO of read addresses.
 */
`default_nettype none

module pathScrambler (
	input wire logic Clock,
	input wire logic arstN,
	dramPortIf.slave inner,
	output oramPkg::slotAddrT dramCmdAddr,
	output dramPkg::dramCmdT dramCmd,
	output logic dramCmdValid,
	input wire logic dramCmdReady,
	input wire oramPkg::dramWordT dramReadData,
	input wire logic dramReadDataValid,
	output logic dramReadDataReady,
	output oramPkg::dramWordT dramWriteData,
	output logic dramWriteDataValid,
	input wire logic dramWriteDataReady
);
	localparam int PtrW = $clog2(dramPkg::TagDepth);

	oramPkg::slotAddrT tagMem [dramPkg::TagDepth];
	logic [PtrW-1:0] tagWrPtrQ, tagRdPtrQ;
	logic [PtrW:0] tagCountQ;
	logic tagFull, tagPush, tagPop, readBlocked;

	oramPkg::slotAddrT wrAddrQ;
	logic wrCmdAccept, wrAccept;
	logic wrValidQ, rdValidQ;
	oramPkg::dramWordT wrDataQ, rdDataQ;

	// Commands pass straight through
	assign tagFull = tagCountQ == dramPkg::TagDepth;
	assign readBlocked = inner.cmd == dramPkg::dramRead && tagFull;
	assign dramCmdAddr = inner.addr;
	assign dramCmd = inner.cmd;
	assign dramCmdValid = inner.cmdValid && !readBlocked;
	assign inner.cmdReady = dramCmdReady && !readBlocked;

	assign tagPush = inner.cmdValid && inner.cmdReady && inner.cmd == dramPkg::dramRead;
	assign wrCmdAccept = inner.cmdValid && inner.cmdReady && inner.cmd == dramPkg::dramWrite;
	assign tagPop = dramReadDataValid && dramReadDataReady;
	assign wrAccept = inner.wrValid && inner.wrReady;

	assign dramReadDataReady = !rdValidQ || inner.rdReady;
	assign inner.rdValid = rdValidQ;
	assign inner.rdData = rdDataQ;

	assign inner.wrReady = !wrValidQ || dramWriteDataReady;
	assign dramWriteDataValid = wrValidQ;
	assign dramWriteData = wrDataQ;

	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN) begin
			tagWrPtrQ <= '0;
			tagRdPtrQ <= '0;
			tagCountQ <= '0;
			wrValidQ <= 1'b0;
			rdValidQ <= 1'b0;
		end else begin
			if (tagPush)
				tagWrPtrQ <= tagWrPtrQ + 1'b1;
			if (tagPop)
				tagRdPtrQ <= tagRdPtrQ + 1'b1;
			case ({tagPush, tagPop})
				2'b10: tagCountQ <= tagCountQ + 1'b1;
				2'b01: tagCountQ <= tagCountQ - 1'b1;
				default: ;
			endcase
			if (wrAccept)
				wrValidQ <= 1'b1;
			else if (dramWriteDataReady)
				wrValidQ <= 1'b0;
			if (tagPop)
				rdValidQ <= 1'b1;
			else if (inner.rdReady)
				rdValidQ <= 1'b0;
		end
	end

	// Write data takes the pad of the write command that came before it
	always_ff @(posedge Clock) begin
		if (tagPush)
			tagMem[tagWrPtrQ] <= inner.addr;
		if (wrCmdAccept)
			wrAddrQ <= inner.addr;
		if (wrAccept)
			wrDataQ <= inner.wrData ^ dramPkg::slotPad(wrAddrQ);
		if (tagPop)
			rdDataQ <= dramReadData ^ dramPkg::slotPad(tagMem[tagRdPtrQ]);
	end

endmodule

`default_nettype wire

//--- backendControl.sv
/*
 * Access sequencer: reads a path into the stash, serves the block,
 * then writes the path back leaf to root from the stash.
 */
`default_nettype none

module backendControl (
	input wire logic Clock,
	input wire logic arstN,
	input wire oramPkg::backendCmdT command,
	input wire oramPkg::pAddrT pAddr,
	input wire oramPkg::leafT currentLeaf,
	input wire oramPkg::leafT remappedLeaf,
	input wire logic commandValid,
	output logic commandReady,
	output oramPkg::blockDataT loadData,
	output logic loadValid,
	input wire logic loadReady,
	input wire oramPkg::blockDataT storeData,
	input wire logic storeValid,
	output logic storeReady,
	stashIf.master stash,
	dramPortIf.master dram,
	output logic walkStart,
	output logic walkAdvance,
	output logic walkReverse,
	input wire oramPkg::slotAddrT walkAddr,
	input wire oramPkg::levelT walkLevel,
	input wire logic walkLast
);
	localparam int PathSlots = oramPkg::TreeLevels * oramPkg::SlotsPerBucket;

	typedef enum logic [2:0] {stIdle, stReadPath, stServe, stWriteBack, stDone} stateT;

	stateT stateQ;
	// Serve: lookup, result, load handshake. Write-back: evict, command, data
	logic [1:0] phaseQ;
	logic [$clog2(PathSlots)-1:0] rdCountQ;
	logic issueDoneQ;

	oramPkg::backendCmdT cmdQ;
	oramPkg::pAddrT pAddrQ;
	oramPkg::leafT leafQ, newLeafQ;
	oramPkg::blockDataT loadDataQ;

	logic cmdAccept, dramCmdAccept, rdAccept, wrAccept, serveDone;

	// ----------------------------------------
	// Frontend handshakes
	// ----------------------------------------
	assign commandReady = stateQ == stIdle;
	assign cmdAccept = commandValid && commandReady;
	assign storeReady = stateQ == stServe && phaseQ == 2'd0 && cmdQ == oramPkg::cmdWrite;
	assign loadValid = stateQ == stServe && phaseQ == 2'd2;
	assign loadData = loadDataQ;

	// ----------------------------------------
	// DRAM side
	// ----------------------------------------
	assign dram.addr = walkAddr;
	assign dram.cmd = (stateQ == stReadPath) ? dramPkg::dramRead : dramPkg::dramWrite;
	assign dram.cmdValid = (stateQ == stReadPath && !issueDoneQ)
		|| (stateQ == stWriteBack && phaseQ == 2'd1);
	assign dramCmdAccept = dram.cmdValid && dram.cmdReady;
	assign dram.rdReady = stateQ == stReadPath;
	assign rdAccept = dram.rdValid && dram.rdReady;
	assign dram.wrValid = stateQ == stWriteBack && phaseQ == 2'd2;
	// Empty slots get an all-zero invalid word
	assign dram.wrData = stash.evFound ? stash.evWord : '0;
	assign wrAccept = dram.wrValid && dram.wrReady;

	// Stash requests
	assign stash.insValid = rdAccept && dram.rdData[oramPkg::WordValidBit];
	assign stash.insWord = dram.rdData;
	assign stash.lookValid = stateQ == stServe && phaseQ == 2'd0
		&& (cmdQ == oramPkg::cmdRead || storeValid);
	assign stash.lookPAddr = pAddrQ;
	assign stash.lookNewLeaf = newLeafQ;
	assign stash.lookWrite = cmdQ == oramPkg::cmdWrite;
	assign stash.lookData = storeData;
	assign stash.evValid = stateQ == stWriteBack && phaseQ == 2'd0;
	assign stash.evLeaf = leafQ;
	assign stash.evLevel = walkLevel;

	// Path walks
	assign serveDone = stateQ == stServe
		&& ((phaseQ == 2'd1 && cmdQ == oramPkg::cmdWrite) || (loadValid && loadReady));
	assign walkStart = cmdAccept || serveDone;
	assign walkReverse = serveDone;
	assign walkAdvance = (stateQ == stReadPath && dramCmdAccept) || wrAccept;

	// ----------------------------------------
	// State machine
	// ----------------------------------------
	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN) begin
			// Done steps to idle, so commandReady rises a cycle after reset
			stateQ <= stDone;
			phaseQ <= '0;
			rdCountQ <= '0;
			issueDoneQ <= 1'b0;
		end else begin
			case (stateQ)
				stIdle: begin
					if (cmdAccept) begin
						stateQ <= stReadPath;
						issueDoneQ <= 1'b0;
					end
				end
				stReadPath: begin
					if (dramCmdAccept && walkLast)
						issueDoneQ <= 1'b1;
					if (rdAccept) begin
						rdCountQ <= rdCountQ + 1'b1;
						if (rdCountQ == PathSlots - 1)
							stateQ <= stServe;
					end
				end
				stServe: begin
					if (serveDone) begin
						stateQ <= stWriteBack;
						phaseQ <= 2'd0;
					end else if (phaseQ == 2'd0 && stash.lookValid) begin
						phaseQ <= 2'd1;
					end else if (phaseQ == 2'd1) begin
						phaseQ <= 2'd2;
					end
				end
				stWriteBack: begin
					if (stash.evValid) begin
						phaseQ <= 2'd1;
					end else if (dramCmdAccept) begin
						phaseQ <= 2'd2;
					end else if (wrAccept) begin
						phaseQ <= 2'd0;
						if (walkLast)
							stateQ <= stDone;
					end
				end
				default: stateQ <= stIdle;
			endcase
		end
	end

	always_ff @(posedge Clock) begin
		if (cmdAccept) begin
			cmdQ <= command;
			pAddrQ <= pAddr;
			leafQ <= currentLeaf;
			newLeafQ <= remappedLeaf;
		end
		if (stateQ == stServe && phaseQ == 2'd1)
			loadDataQ <= stash.lookResult;
	end

endmodule

`default_nettype wire

//--- pathOramBackend.sv
/*
 * Path ORAM backend top level with plain frontend and DRAM ports.
 * Holds the controller, stash, path walker and pad scrambler.
 */
`default_nettype none

module pathOramBackend (
	input wire logic Clock,
	input wire logic arstN,

	input wire oramPkg::backendCmdT command,
	input wire oramPkg::pAddrT pAddr,
	input wire oramPkg::leafT currentLeaf,
	input wire oramPkg::leafT remappedLeaf,
	input wire logic commandValid,
	output logic commandReady,

	output oramPkg::blockDataT loadData,
	output logic loadValid,
	input wire logic loadReady,

	input wire oramPkg::blockDataT storeData,
	input wire logic storeValid,
	output logic storeReady,

	output oramPkg::slotAddrT dramCmdAddr,
	output dramPkg::dramCmdT dramCmd,
	output logic dramCmdValid,
	input wire logic dramCmdReady,
	input wire oramPkg::dramWordT dramReadData,
	input wire logic dramReadDataValid,
	output logic dramReadDataReady,
	output oramPkg::dramWordT dramWriteData,
	output logic dramWriteDataValid,
	input wire logic dramWriteDataReady,

	output logic stashOverflow
);
	stashIf stashBus ();
	dramPortIf dramBus ();

	logic walkStart, walkAdvance, walkReverse, walkLast;
	oramPkg::slotAddrT walkAddr;
	oramPkg::levelT walkLevel;

	assign stashOverflow = stashBus.overflow;

	backendControl backendControl_i (
		.Clock, .arstN,
		.command, .pAddr, .currentLeaf, .remappedLeaf, .commandValid, .commandReady,
		.loadData, .loadValid, .loadReady,
		.storeData, .storeValid, .storeReady,
		.stash(stashBus.master),
		.dram(dramBus.master),
		.walkStart, .walkAdvance, .walkReverse, .walkAddr, .walkLevel, .walkLast
	);

	stash stash_i (
		.Clock, .arstN,
		.port(stashBus.slave)
	);

	// Forward walks latch the leaf while the command is presented
	pathAddrGen pathAddrGen_i (
		.Clock, .arstN,
		.leaf(currentLeaf),
		.start(walkStart),
		.advance(walkAdvance),
		.reverse(walkReverse),
		.addr(walkAddr),
		.level(walkLevel),
		.last(walkLast)
	);

	pathScrambler pathScrambler_i (
		.Clock, .arstN,
		.inner(dramBus.slave),
		.dramCmdAddr, .dramCmd, .dramCmdValid, .dramCmdReady,
		.dramReadData, .dramReadDataValid, .dramReadDataReady,
		.dramWriteData, .dramWriteDataValid, .dramWriteDataReady
	);

endmodule

`default_nettype wire

//--- tbDramModel.sv
/*
 * Behavioral DRAM for the backend testbench: in-order reads, random ready stalls.
 * The slot array starts at the scrambled empty word and is read by the testbench.
 */
`default_nettype none

module tbDramModel (
	input wire logic Clock,
	input wire logic arstN,
	input wire oramPkg::slotAddrT cmdAddr,
	input wire dramPkg::dramCmdT cmd,
	input wire logic cmdValid,
	output logic cmdReady,
	output oramPkg::dramWordT readData,
	output logic readDataValid,
	input wire logic readDataReady,
	input wire oramPkg::dramWordT writeData,
	input wire logic writeDataValid,
	output logic writeDataReady
);
	timeunit 1ns;
	timeprecision 1ps;

	oramPkg::dramWordT mem [oramPkg::NumSlots];
	oramPkg::slotAddrT readQ [$];
	oramPkg::slotAddrT writeQ [$];
	logic readTaken;
	integer stallSeed;

	// Key XOR the address byte in all eight lanes, i.e. an empty slot after scrambling
	function automatic oramPkg::dramWordT emptyWord(input oramPkg::slotAddrT a);
		return dramPkg::ScrambleKey ^ {8{3'b000, a}};
	endfunction

	// True about one call in four
	function automatic bit stall();
		return ($random(stallSeed) & 3) == 0;
	endfunction

	initial begin
		stallSeed = 36;
		for (int s = 0; s < oramPkg::NumSlots; s++)
			mem[s] = emptyWord(5'(s));
		cmdReady = 1'b0;
		readData = '0;
		readDataValid = 1'b0;
		writeDataReady = 1'b0;
		readTaken = 1'b0;
	end

	// ----------------------------------------
	// Handshakes at the rising edge
	// ----------------------------------------
	always @(posedge Clock) begin
		if (!arstN) begin
			readQ.delete();
			writeQ.delete();
			readTaken = 1'b0;
		end else begin
			if (cmdValid && cmdReady) begin
				if (cmd == dramPkg::dramRead)
					readQ.push_back(cmdAddr);
				else
					writeQ.push_back(cmdAddr);
			end
			if (writeDataValid && writeDataReady && writeQ.size() != 0)
				mem[writeQ.pop_front()] = writeData;
			readTaken = readDataValid && readDataReady;
		end
	end

	// ----------------------------------------
	// Outputs change on the falling edge
	// ----------------------------------------
	always @(negedge Clock) begin
		if (!arstN) begin
			cmdReady = 1'b0;
			readDataValid = 1'b0;
			writeDataReady = 1'b0;
		end else begin
			if (readTaken)
				readDataValid = 1'b0;
			if (!readDataValid && readQ.size() != 0 && !stall()) begin
				readData = mem[readQ.pop_front()];
				readDataValid = 1'b1;
			end
			// Later reads must see a write, so hold commands until its data lands
			cmdReady = writeQ.size() == 0 && !stall();
			writeDataReady = !stall();
		end
	end

endmodule

`default_nettype wire

//--- tbPathOramBackend.sv
/*
 * Directed testbench for the Path ORAM backend against a behavioral DRAM.
 * Keeps a reference map of block data and leaves and scans DRAM after every access.
 */
`default_nettype none

module tbPathOramBackend;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int ClockPeriod = 20;
	// About 60 accesses; allow 80 at 250 cycles each
	localparam int MaxAccesses = 80;
	localparam int CyclesPerAccess = 250;
	localparam int WatchdogNs = MaxAccesses * CyclesPerAccess * ClockPeriod;

	localparam int RandomOps = 40;
	localparam int RandomAddrs = 6;
	localparam logic [7:0] RandomBase = 8'h20;

	logic Clock, arstN;
	oramPkg::backendCmdT command;
	oramPkg::pAddrT pAddr;
	oramPkg::leafT currentLeaf, remappedLeaf;
	logic commandValid, commandReady;
	oramPkg::blockDataT loadData, storeData;
	logic loadValid, loadReady, storeValid, storeReady;
	oramPkg::slotAddrT dramCmdAddr;
	dramPkg::dramCmdT dramCmd;
	logic dramCmdValid, dramCmdReady;
	oramPkg::dramWordT dramReadData, dramWriteData;
	logic dramReadDataValid, dramReadDataReady;
	logic dramWriteDataValid, dramWriteDataReady;
	logic stashOverflow;

	// Reference map by program address
	oramPkg::blockDataT refData [256];
	oramPkg::leafT refLeaf [256];
	logic refLive [256];

	integer seed;
	int errorCount, testsPassed, testsFailed;
	int treeErrors, cipherErrors;

	pathOramBackend pathOramBackend_i (
		.Clock, .arstN,
		.command, .pAddr, .currentLeaf, .remappedLeaf, .commandValid, .commandReady,
		.loadData, .loadValid, .loadReady,
		.storeData, .storeValid, .storeReady,
		.dramCmdAddr, .dramCmd, .dramCmdValid, .dramCmdReady,
		.dramReadData, .dramReadDataValid, .dramReadDataReady,
		.dramWriteData, .dramWriteDataValid, .dramWriteDataReady,
		.stashOverflow
	);

	tbDramModel dram_i (
		.Clock, .arstN,
		.cmdAddr(dramCmdAddr), .cmd(dramCmd), .cmdValid(dramCmdValid), .cmdReady(dramCmdReady),
		.readData(dramReadData), .readDataValid(dramReadDataValid),
		.readDataReady(dramReadDataReady),
		.writeData(dramWriteData), .writeDataValid(dramWriteDataValid),
		.writeDataReady(dramWriteDataReady)
	);

	always #(ClockPeriod / 2) Clock = ~Clock;

	// ----------------------------------------
	// Reference helpers
	// ----------------------------------------
	function automatic oramPkg::dramWordT expectedPad(input oramPkg::slotAddrT a);
		return dramPkg::ScrambleKey ^ {8{3'b000, a}};
	endfunction

	// Valid flag, address, leaf, 20 zero bits, data
	function automatic oramPkg::dramWordT plainWord(input logic [7:0] a, input logic [2:0] lf,
		input logic [31:0] d);
		return {1'b1, a, lf, 20'b0, d};
	endfunction

	// Climb from the leaf node to the root looking for the bucket
	function automatic bit onPath(input int bucket, input oramPkg::leafT lf);
		int node;
		node = oramPkg::NumLeaves - 1 + int'(lf);
		for (int l = 0; l < oramPkg::TreeLevels; l++) begin
			if (node == bucket)
				return 1'b1;
			node = (node - 1) / 2;
		end
		return 1'b0;
	endfunction

	task automatic reportMismatch(input string msg);
		$display("mismatch at %0t ns: %s", $time, msg);
		errorCount++;
	endtask

	task automatic finishTest(input string name, input int errors);
		if (errors == 0) begin
			testsPassed++;
			$display("test %s: ok", name);
		end else begin
			testsFailed++;
			$display("test %s: %0d errors", name, errors);
		end
	endtask

	// Decode every slot and hold it against the reference map
	task automatic checkTree();
		oramPkg::dramWordT raw, plain;
		oramPkg::pAddrT p;
		oramPkg::leafT lf;
		int seenCount [256];
		for (int a = 0; a < 256; a++)
			seenCount[a] = 0;
		for (int s = 0; s < oramPkg::NumSlots; s++) begin
			raw = dram_i.mem[s];
			plain = raw ^ expectedPad(5'(s));
			if (!plain[63]) begin
				if (plain != '0) begin
					cipherErrors++;
					reportMismatch($sformatf("slot %0d empty word decodes to %h", s, plain));
				end
			end else begin
				p = plain[62:55];
				lf = plain[54:52];
				seenCount[p]++;
				if (!onPath(s / 2, lf)) begin
					treeErrors++;
					reportMismatch($sformatf("slot %0d block %h leaf %0d off path", s, p, lf));
				end
				if (!refLive[p]) begin
					treeErrors++;
					reportMismatch($sformatf("slot %0d holds unwritten block %h", s, p));
				end else begin
					if (lf != refLeaf[p]) begin
						treeErrors++;
						reportMismatch($sformatf("block %h leaf %0d, expected %0d",
							p, lf, refLeaf[p]));
					end
					if (raw == plainWord(p, refLeaf[p], refData[p])) begin
						cipherErrors++;
						reportMismatch($sformatf("slot %0d stored unscrambled", s));
					end
					if (raw != (plainWord(p, refLeaf[p], refData[p]) ^ expectedPad(5'(s)))) begin
						cipherErrors++;
						reportMismatch($sformatf("slot %0d raw %h, expected %h", s, raw,
							plainWord(p, refLeaf[p], refData[p]) ^ expectedPad(5'(s))));
					end
				end
			end
		end
		for (int a = 0; a < 256; a++) begin
			if (seenCount[a] > 1) begin
				treeErrors++;
				reportMismatch($sformatf("block %h found in %0d slots", a, seenCount[a]));
			end
		end
	endtask

	// ----------------------------------------
	// One frontend access
	// ----------------------------------------
	task automatic access(input logic isWrite, input oramPkg::pAddrT addr,
		input oramPkg::blockDataT data, output oramPkg::blockDataT result);
		oramPkg::leafT newLeaf;
		newLeaf = oramPkg::leafT'($random(seed));
		result = '0;
		@(negedge Clock);
		command = isWrite ? oramPkg::cmdWrite : oramPkg::cmdRead;
		pAddr = addr;
		currentLeaf = refLeaf[addr];
		remappedLeaf = newLeaf;
		commandValid = 1'b1;
		if (isWrite) begin
			storeData = data;
			storeValid = 1'b1;
		end
		// Ready signals follow the FSM state only, so they are stable here
		while (!commandReady)
			@(negedge Clock);
		@(negedge Clock);
		commandValid = 1'b0;
		if (isWrite) begin
			while (!storeReady)
				@(negedge Clock);
			@(negedge Clock);
			storeValid = 1'b0;
		end else begin
			while (!loadValid)
				@(negedge Clock);
			result = loadData;
			@(negedge Clock);
		end
		// Done once idle and the last write word has left the scrambler
		while (!commandReady || dramWriteDataValid)
			@(negedge Clock);
		refLeaf[addr] = newLeaf;
		if (isWrite) begin
			refData[addr] = data;
			refLive[addr] = 1'b1;
		end
		checkTree();
	endtask

	task automatic readAndCompare(input oramPkg::pAddrT addr);
		oramPkg::blockDataT got;
		access(1'b0, addr, '0, got);
		if (got != refData[addr])
			reportMismatch($sformatf("read %h returned %h, expected %h", addr, got, refData[addr]));
	endtask

	task automatic randomAccess();
		oramPkg::pAddrT addr;
		oramPkg::blockDataT got;
		addr = RandomBase + oramPkg::pAddrT'($unsigned($random(seed)) % RandomAddrs);
		if ($random(seed) & 1)
			access(1'b1, addr, oramPkg::blockDataT'($random(seed)), got);
		else
			readAndCompare(addr);
	endtask

	task automatic checkIdle();
		@(negedge Clock);
		if (!commandReady)
			reportMismatch("commandReady low while idle between tests");
		if (stashOverflow)
			reportMismatch("stashOverflow set");
	endtask

	// ----------------------------------------
	// Directed tests
	// ----------------------------------------
	task automatic readUnwrittenBlock();
		int startErr;
		startErr = errorCount;
		readAndCompare(8'hA5);
		finishTest("1 read of unwritten block", errorCount - startErr);
	endtask

	task automatic writeThenRead();
		int startErr;
		oramPkg::blockDataT got;
		startErr = errorCount;
		access(1'b1, 8'h11, oramPkg::blockDataT'($random(seed)), got);
		readAndCompare(8'h11);
		finishTest("2 write then read", errorCount - startErr);
	endtask

	task automatic randomMix();
		int startErr;
		startErr = errorCount;
		for (int i = 0; i < RandomOps; i++)
			randomAccess();
		finishTest("3 random mix under back-pressure", errorCount - startErr);
	endtask

	task automatic placementScan();
		for (int i = 0; i < 10; i++)
			randomAccess();
		finishTest("4 path placement of DRAM blocks", treeErrors);
	endtask

	task automatic scrambledWrites();
		oramPkg::blockDataT got;
		for (int i = 0; i < RandomAddrs; i++)
			access(1'b1, RandomBase + 8'(i), oramPkg::blockDataT'($random(seed)), got);
		finishTest("5 DRAM words scrambled with slot pad", cipherErrors);
	endtask

	task automatic idleStatus();
		int startErr;
		startErr = errorCount;
		checkIdle();
		finishTest("6 idle and overflow status", errorCount - startErr);
	endtask

	// ----------------------------------------
	// Main sequence
	// ----------------------------------------
	initial begin
		seed = 36;
		errorCount = 0;
		testsPassed = 0;
		testsFailed = 0;
		treeErrors = 0;
		cipherErrors = 0;
		for (int a = 0; a < 256; a++) begin
			refData[a] = '0;
			refLeaf[a] = '0;
			refLive[a] = 1'b0;
		end
		Clock = 1'b0;
		arstN = 1'b0;
		command = oramPkg::cmdRead;
		pAddr = '0;
		currentLeaf = '0;
		remappedLeaf = '0;
		commandValid = 1'b0;
		loadReady = 1'b1;
		storeData = '0;
		storeValid = 1'b0;

		repeat (4) @(posedge Clock);
		@(negedge Clock);
		if (commandReady || loadValid || storeReady || dramCmdValid || dramWriteDataValid
			|| stashOverflow)
			reportMismatch("outputs not low during reset");
		arstN = 1'b1;
		@(negedge Clock);
		if (!commandReady)
			reportMismatch("commandReady not high one cycle after reset release");
		while (!commandReady)
			@(negedge Clock);

		readUnwrittenBlock();
		checkIdle();
		writeThenRead();
		checkIdle();
		randomMix();
		checkIdle();
		placementScan();
		checkIdle();
		scrambledWrites();
		idleStatus();

		$display("tests: %0d passed, %0d failed, %0d errors", testsPassed, testsFailed,
			errorCount);
		if (errorCount == 0 && testsFailed == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

	initial begin
		#(WatchdogNs);
		$display("timeout: the tests did not finish within %0d ns", WatchdogNs);
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- compile.f
oramPkg.sv
dramPkg.sv
oramIfs.sv
pathAddrGen.sv
stash.sv
pathScrambler.sv
backendControl.sv
pathOramBackend.sv
tbDramModel.sv
tbPathOramBackend.sv

//--- Makefile
# Verilator build and run of the Path ORAM backend testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal --top-module tbPathOramBackend -f compile.f -Mdir obj_dir
	./obj_dir/VtbPathOramBackend | tee sim.log
	@if grep -q "Simulation finished: FAIL" sim.log; then echo "test failed"; exit 1; fi
	@if ! grep -q "Simulation finished: PASS" sim.log; then echo "no result in log"; exit 1; fi

clean:
	rm -rf obj_dir sim.log
